/* design/i2c_pkg.sv */
package i2c_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Timing and buffer sizes
    ////////////////////////////////////////////////////////////////////////////

    // Clock cycles per quarter of an SCL period
    localparam int QUARTER_DIV   = 8;
    localparam int QUARTER_CNT_W = $clog2(QUARTER_DIV);

    // Depth of the write and read byte buffers
    localparam int MAX_BYTES = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_STATUS = 8'h04;
    localparam logic [7:0] ADDR_WDATA0 = 8'h08;
    localparam logic [7:0] ADDR_WDATA1 = 8'h0C;
    localparam logic [7:0] ADDR_RDATA0 = 8'h10;
    localparam logic [7:0] ADDR_RDATA1 = 8'h14;

    // APB request from the host
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB response back to the host
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Transfer command, counts already clipped
    typedef struct packed {
        logic [6:0] addr;
        logic [3:0] wr_cnt;
        logic [3:0] rd_cnt;
    } i2c_cmd_t;

    typedef struct packed {
        logic busy;
        logic finish;
        logic error;
    } i2c_status_t;

    // Open-drain enables, high pulls the line low
    typedef struct packed {
        logic scl_oe;
        logic sda_oe;
    } i2c_pad_t;

    // Quarter phases of one SCL period, in tick order
    typedef enum logic [1:0] {
        LOW_MID,
        RISE,
        HIGH_MID,
        FALL
    } i2c_phase_t;

endpackage

/* design/i2c_apb_regs.sv */
`timescale 1ns/1ps

module i2c_apb_regs
    import i2c_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output i2c_cmd_t    cmd,
    output logic        start,
    input  i2c_status_t status,
    input  logic [2:0]  wr_index,
    output logic [7:0]  wr_byte,
    input  logic        rd_strobe,
    input  logic [2:0]  rd_index,
    input  logic [7:0]  rd_byte
);

    // Byte k of the buffer lives in bits 8k+7:8k of the register pair
    logic [MAX_BYTES-1:0][7:0] wr_mem;
    logic [MAX_BYTES-1:0][7:0] rd_mem;

    logic access;
    logic wr_access;
    logic ctrl_blocked;

    // Limit a requested byte count to the buffer depth
    function automatic logic [3:0] clip_count(input logic [3:0] cnt);
        logic [3:0] limit;
        limit = 4'(MAX_BYTES);
        if (cnt > limit) begin
            return limit;
        end
        return cnt;
    endfunction

    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;

    // Transfer in flight, or about to start from the previous CTRL write
    assign ctrl_blocked = status.busy || start;

    ////////////////////////////////////////////////////////////////////////////
    // Command register and start pulse
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd   <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            // CTRL writes are dropped entirely during a transfer
            if (wr_access && apb_req.paddr == ADDR_CTRL && !ctrl_blocked) begin
                cmd.addr   <= apb_req.pwdata[7:1];
                cmd.wr_cnt <= clip_count(apb_req.pwdata[11:8]);
                cmd.rd_cnt <= clip_count(apb_req.pwdata[15:12]);
                start      <= apb_req.pwdata[0];
            end
        end
    end

    // Write buffer, loaded by the host
    always_ff @(posedge clk) begin
        if (wr_access && apb_req.paddr == ADDR_WDATA0) begin
            wr_mem[3:0] <= apb_req.pwdata;
        end
        if (wr_access && apb_req.paddr == ADDR_WDATA1) begin
            wr_mem[7:4] <= apb_req.pwdata;
        end
    end

    // Read buffer, one byte per strobe from the sequencer
    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            rd_mem[rd_index] <= rd_byte;
        end
    end

    // Byte the sequencer asks for, no latency
    assign wr_byte = wr_mem[wr_index];

    ////////////////////////////////////////////////////////////////////////////
    // Read mux and error decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = 1'b0;
        case (apb_req.paddr)
            ADDR_CTRL: begin
                // Start bit reads back as zero
                apb_rsp.prdata = {16'd0, cmd.rd_cnt, cmd.wr_cnt, cmd.addr, 1'b0};
            end
            ADDR_STATUS: begin
                apb_rsp.prdata = {29'd0, status.error, status.finish, status.busy};
                apb_rsp.pslverr = wr_access;
            end
            ADDR_WDATA0: apb_rsp.prdata = wr_mem[3:0];
            ADDR_WDATA1: apb_rsp.prdata = wr_mem[7:4];
            ADDR_RDATA0: begin
                apb_rsp.prdata  = rd_mem[3:0];
                apb_rsp.pslverr = wr_access;
            end
            ADDR_RDATA1: begin
                apb_rsp.prdata  = rd_mem[7:4];
                apb_rsp.pslverr = wr_access;
            end
            // Unmapped offset
            default: apb_rsp.pslverr = access;
        endcase
    end

endmodule

/* design/i2c_scl_timer.sv */
`timescale 1ns/1ps

module i2c_scl_timer
    import i2c_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    output logic       tick,
    output i2c_phase_t phase
);

    logic [QUARTER_CNT_W-1:0] count;
    i2c_phase_t               phase_q;

    ////////////////////////////////////////////////////////////////////////////
    // Quarter-period divider
    ////////////////////////////////////////////////////////////////////////////

    // Disabled timer sits reloaded, so the first tick is always LOW_MID
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            count   <= QUARTER_CNT_W'(QUARTER_DIV - 1);
            phase_q <= LOW_MID;
        end else if (count == '0) begin
            count   <= QUARTER_CNT_W'(QUARTER_DIV - 1);
            // Wraps FALL back to LOW_MID
            phase_q <= i2c_phase_t'(phase_q + 2'd1);
        end else begin
            count <= count - 1'b1;
        end
    end

    // One cycle per quarter, tagged with the phase it ends
    assign tick  = enable && (count == '0);
    assign phase = phase_q;

endmodule

/* design/i2c_byte_shifter.sv */
`timescale 1ns/1ps

module i2c_byte_shifter
    import i2c_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    input  logic [7:0] load_byte,
    input  logic       shift,
    input  logic       sample,
    input  logic       sda_in,
    output logic       tx_bit,
    output logic [7:0] rx_byte,
    output logic       last_bit
);

    logic [7:0] tx_q;
    logic [7:0] rx_q;
    logic [2:0] bit_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Bit index
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_idx <= '0;
        end else if (load) begin
            bit_idx <= '0;
        end else if (shift) begin
            bit_idx <= bit_idx + 3'd1;
        end
    end

    // Transmit side, MSB first
    always_ff @(posedge clk) begin
        if (load) begin
            tx_q <= load_byte;
        end else if (shift) begin
            tx_q <= {tx_q[6:0], 1'b0};
        end
    end

    // Receive side, new bit enters at the LSB
    always_ff @(posedge clk) begin
        if (sample) begin
            rx_q <= {rx_q[6:0], sda_in};
        end
    end

    assign tx_bit   = tx_q[7];
    assign rx_byte  = rx_q;
    // Bit 0 on the wire, ACK slot comes next
    assign last_bit = (bit_idx == 3'd7);

endmodule

/* design/i2c_master_fsm.sv */
`timescale 1ns/1ps

module i2c_master_fsm
    import i2c_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  i2c_cmd_t    cmd,
    output i2c_status_t status,
    input  logic        tick,
    input  i2c_phase_t  phase,
    output logic        timer_en,
    output logic [2:0]  wr_index,
    input  logic [7:0]  wr_byte,
    output logic        rd_strobe,
    output logic [2:0]  rd_index,
    output logic        load,
    output logic [7:0]  load_byte,
    output logic        shift,
    output logic        sample,
    input  logic        tx_bit,
    input  logic [7:0]  rx_byte,
    input  logic        last_bit,
    input  logic        sda_in,
    output i2c_pad_t    pad
);

    typedef enum logic [3:0] {
        IDLE, START, ADDR, ADDR_ACK, WRITE, WRITE_ACK,
        RESTART, READ, READ_ACK, STOP
    } state_t;

    state_t     state;
    logic [3:0] byte_cnt;
    logic       read_phase;
    logic       nack_q;
    logic       abort;

    // Same counter walks the write and the read buffer
    assign wr_index = byte_cnt[2:0];
    assign rd_index = byte_cnt[2:0];

    ////////////////////////////////////////////////////////////////////////////
    // Shifter controls and read strobe
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        load      = 1'b0;
        load_byte = wr_byte;
        shift     = 1'b0;
        sample    = 1'b0;
        rd_strobe = 1'b0;
        if (tick) begin
            case (state)
                START, RESTART: begin
                    // Address byte with the R/W bit set only after a repeated START
                    load      = (phase == FALL);
                    load_byte = {cmd.addr, state == RESTART};
                end
                ADDR, WRITE: shift = (phase == FALL) && !last_bit;
                READ: begin
                    sample    = (phase == HIGH_MID);
                    shift     = (phase == FALL) && !last_bit;
                    rd_strobe = (phase == FALL) && last_bit;
                end
                // Next write byte or just a bit index rewind
                ADDR_ACK, WRITE_ACK, READ_ACK: load = (phase == FALL);
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            status     <= '0;
            pad        <= '0;
            timer_en   <= 1'b0;
            byte_cnt   <= '0;
            read_phase <= 1'b0;
            nack_q     <= 1'b0;
            abort      <= 1'b0;
        end else if (state == IDLE) begin
            if (start) begin
                status   <= '{busy: 1'b1, finish: 1'b0, error: 1'b0};
                abort    <= 1'b0;
                timer_en <= 1'b1;
                state    <= START;
            end
        end else if (tick) begin
            case (phase)
                // Data changes while SCL is low
                LOW_MID: begin
                    case (state)
                        ADDR, WRITE: pad.sda_oe <= !tx_bit;
                        // ACK every byte but the last
                        READ_ACK:    pad.sda_oe <= (byte_cnt != cmd.rd_cnt);
                        STOP:        pad.sda_oe <= 1'b1;
                        default:     pad.sda_oe <= 1'b0;
                    endcase
                end
                RISE: pad.scl_oe <= 1'b0;
                HIGH_MID: begin
                    case (state)
                        START, RESTART:      pad.sda_oe <= 1'b1;
                        ADDR_ACK, WRITE_ACK: nack_q <= sda_in;
                        STOP:                pad.sda_oe <= 1'b0;
                        default: ;
                    endcase
                end
                FALL: begin
                    // SCL stays released after the STOP
                    pad.scl_oe <= (state != STOP);
                    case (state)
                        START, RESTART: begin
                            read_phase <= (state == RESTART);
                            byte_cnt   <= '0;
                            state      <= ADDR;
                        end
                        ADDR: begin
                            if (last_bit) begin
                                state <= ADDR_ACK;
                            end
                        end
                        WRITE: begin
                            if (last_bit) begin
                                byte_cnt <= byte_cnt + 4'd1;
                                state    <= WRITE_ACK;
                            end
                        end
                        READ: begin
                            if (last_bit) begin
                                byte_cnt <= byte_cnt + 4'd1;
                                state    <= READ_ACK;
                            end
                        end
                        ADDR_ACK: begin
                            if (nack_q) begin
                                abort <= 1'b1;
                                state <= STOP;
                            end else if (read_phase) begin
                                state <= READ;
                            end else if (cmd.wr_cnt != '0) begin
                                state <= WRITE;
                            end else if (cmd.rd_cnt != '0) begin
                                state <= RESTART;
                            end else begin
                                // Address probe only
                                state <= STOP;
                            end
                        end
                        WRITE_ACK: begin
                            if (nack_q) begin
                                abort <= 1'b1;
                                state <= STOP;
                            end else if (byte_cnt != cmd.wr_cnt) begin
                                state <= WRITE;
                            end else if (cmd.rd_cnt != '0) begin
                                state <= RESTART;
                            end else begin
                                state <= STOP;
                            end
                        end
                        READ_ACK: state <= (byte_cnt == cmd.rd_cnt) ? STOP : READ;
                        STOP: begin
                            status   <= '{busy: 1'b0, finish: 1'b1, error: abort};
                            timer_en <= 1'b0;
                            state    <= IDLE;
                        end
                        default: state <= IDLE;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

/* design/i2c_master_top.sv */
`timescale 1ns/1ps

module i2c_master_top
    import i2c_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  logic     sda_in,
    output i2c_pad_t pad
);

    i2c_cmd_t    cmd;
    i2c_status_t status;
    i2c_phase_t  phase;
    logic        start;
    logic        tick;
    logic        timer_en;
    logic [2:0]  wr_index;
    logic [7:0]  wr_byte;
    logic        rd_strobe;
    logic [2:0]  rd_index;
    logic        load;
    logic [7:0]  load_byte;
    logic        shift;
    logic        sample;
    logic        tx_bit;
    logic [7:0]  rx_byte;
    logic        last_bit;

    ////////////////////////////////////////////////////////////////////////////
    // Host side registers
    ////////////////////////////////////////////////////////////////////////////

    i2c_apb_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cmd       (cmd),
        .start     (start),
        .status    (status),
        .wr_index  (wr_index),
        .wr_byte   (wr_byte),
        .rd_strobe (rd_strobe),
        .rd_index  (rd_index),
        .rd_byte   (rx_byte)
    );

    // Quarter-period ticks for SCL
    i2c_scl_timer u_timer (
        .clk    (clk),
        .reset  (reset),
        .enable (timer_en),
        .tick   (tick),
        .phase  (phase)
    );

    i2c_master_fsm u_fsm (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .cmd       (cmd),
        .status    (status),
        .tick      (tick),
        .phase     (phase),
        .timer_en  (timer_en),
        .wr_index  (wr_index),
        .wr_byte   (wr_byte),
        .rd_strobe (rd_strobe),
        .rd_index  (rd_index),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .sample    (sample),
        .tx_bit    (tx_bit),
        .rx_byte   (rx_byte),
        .last_bit  (last_bit),
        .sda_in    (sda_in),
        .pad       (pad)
    );

    // Serial data path
    i2c_byte_shifter u_shifter (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .sample    (sample),
        .sda_in    (sda_in),
        .tx_bit    (tx_bit),
        .rx_byte   (rx_byte),
        .last_bit  (last_bit)
    );

endmodule

/* verif/i2c_slave_model.sv */
`timescale 1ns/1ps

module i2c_slave_model
    import i2c_pkg::*;
(
    input  i2c_pad_t pad,
    output logic     scl,
    output logic     sda
);

    localparam logic [6:0] SLAVE_ADDR = 7'h50;

    // Bytes written to this slave, in bus order
    logic [7:0] wr_log [$];

    logic       drive_low  = 1'b0;
    logic       prev_scl   = 1'b1;
    logic       prev_sda   = 1'b1;
    logic [7:0] shift_reg  = '0;
    logic [7:0] tx_byte    = '0;
    int         bit_cnt    = 0;
    int         rd_idx     = 0;
    logic       in_addr    = 1'b0;
    logic       selected   = 1'b0;
    logic       reading    = 1'b0;
    logic       first_read = 1'b0;
    logic       ack_phase  = 1'b0;
    logic       master_ack = 1'b0;

    // Wired-AND bus with pull-ups
    assign scl = !pad.scl_oe;
    assign sda = !(pad.sda_oe || drive_low);

    ////////////////////////////////////////////////////////////////////////////
    // Bus watcher
    ////////////////////////////////////////////////////////////////////////////

    always @(scl or sda) begin
        if (!$isunknown({scl, sda})) begin
            if (scl == prev_scl) begin
                // SDA falling with SCL high, START or repeated START
                if (scl && prev_sda && !sda) begin
                    bit_cnt   = 0;
                    in_addr   = 1'b1;
                    selected  = 1'b0;
                    reading   = 1'b0;
                    ack_phase = 1'b0;
                    drive_low = 1'b0;
                end else if (scl && !prev_sda && sda) begin
                    // STOP
                    in_addr   = 1'b0;
                    selected  = 1'b0;
                    reading   = 1'b0;
                    ack_phase = 1'b0;
                    drive_low = 1'b0;
                end
            end else if (scl) begin
                // Rising SCL, data is stable
                if (ack_phase) begin
                    master_ack = !sda;
                end else if (bit_cnt < 8) begin
                    shift_reg = {shift_reg[6:0], sda};
                    bit_cnt++;
                end
            end else begin
                // Falling SCL, slave may change SDA now
                if (ack_phase) begin
                    ack_phase = 1'b0;
                    bit_cnt   = 0;
                    drive_low = 1'b0;
                    if (reading && (first_read || master_ack)) begin
                        // Read byte k is 0xA0 plus k
                        tx_byte    = 8'hA0 + 8'(rd_idx);
                        drive_low  = !tx_byte[7];
                        first_read = 1'b0;
                    end else begin
                        reading = 1'b0;
                    end
                end else if (bit_cnt == 8) begin
                    ack_phase = 1'b1;
                    if (in_addr) begin
                        in_addr    = 1'b0;
                        selected   = (shift_reg[7:1] == SLAVE_ADDR);
                        reading    = selected && shift_reg[0];
                        first_read = reading;
                        rd_idx     = 0;
                        drive_low  = selected;
                    end else if (selected && !reading) begin
                        wr_log.push_back(shift_reg);
                        drive_low = 1'b1;
                    end else if (reading) begin
                        // Let go so the master can ACK or NACK
                        drive_low = 1'b0;
                        rd_idx++;
                    end
                end else if (reading && bit_cnt > 0) begin
                    drive_low = !tx_byte[7 - bit_cnt];
                end
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

/* verif/i2c_tb_top.sv */
`timescale 1ns/1ps

module i2c_tb_top
    import i2c_pkg::*;
();

    // One row per transfer
    typedef struct packed {
        logic [6:0] addr;
        logic [3:0] wr_cnt;
        logic [3:0] rd_cnt;
        logic       exp_error;
        logic       busy_write;
    } test_vec_t;

    localparam int NUM_TESTS = 8;

    // Worst-case transfer length in cycles with a margin of two
    localparam int WATCHDOG_CYCLES =
        2 * NUM_TESTS * (MAX_BYTES * 2 + 4) * 9 * 4 * QUARTER_DIV;

    test_vec_t tests [NUM_TESTS] = '{
        '{7'h50, 4'd5,  4'd5,  1'b0, 1'b0},
        '{7'h50, 4'd5,  4'd0,  1'b0, 1'b0},
        '{7'h50, 4'd0,  4'd5,  1'b0, 1'b0},
        '{7'h50, 4'd0,  4'd0,  1'b0, 1'b0},
        '{7'h3C, 4'd0,  4'd0,  1'b1, 1'b0},
        '{7'h3C, 4'd3,  4'd0,  1'b1, 1'b0},
        '{7'h50, 4'd12, 4'd12, 1'b0, 1'b0},
        // CTRL rewritten mid-transfer
        '{7'h50, 4'd3,  4'd2,  1'b0, 1'b1}
    };

    logic     clk;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    i2c_pad_t pad;
    logic     scl;
    logic     sda;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int seed;

    i2c_master_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .sda_in  (sda),
        .pad     (pad)
    );

    i2c_slave_model u_slave (
        .pad (pad),
        .scl (scl),
        .sda (sda)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB setup phase then access phase
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic slverr);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // Access phase completes here
        @(posedge clk);
        slverr = apb_rsp.pslverr;
        check_flag(apb_rsp.pready, 1'b1, "pready in write access phase");
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        data   = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_flag(apb_rsp.pready, 1'b1, "pready in read access phase");
        apb_req <= '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_status(input i2c_status_t got, input i2c_status_t exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s busy/finish/error %b, expected %b",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pad(input i2c_pad_t got, input i2c_pad_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s scl/sda enables %b, expected %b",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // One line per finished test
    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: %0d mismatches", $time, name, errors - err_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0]  wr_bytes [MAX_BYTES];
        logic [31:0] word;
        logic [63:0] rd_all;
        logic        slverr;
        int          eff_wr;
        int          eff_rd;
        int          exp_rec;
        int          exp_fetch;
        int          err_before;
        i2c_status_t st;
        i2c_status_t st_exp;

        apb_req = '0;
        reset   = 1'b1;
        seed    = 32'ha0807d31;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Idle after reset
        err_before = errors;
        check_pad(pad, '0, "pad after reset");
        check_flag(scl && sda, 1'b1, "bus lines after reset");
        apb_read(ADDR_STATUS, word, slverr);
        check_word(word, 32'd0, "STATUS after reset");
        report_test("reset state", err_before);

        for (int i = 0; i < NUM_TESTS; i++) begin
            err_before = errors;
            // Counts above the buffer depth are clipped
            eff_wr    = (tests[i].wr_cnt > MAX_BYTES) ? MAX_BYTES : int'(tests[i].wr_cnt);
            eff_rd    = (tests[i].rd_cnt > MAX_BYTES) ? MAX_BYTES : int'(tests[i].rd_cnt);
            exp_rec   = tests[i].exp_error ? 0 : eff_wr;
            exp_fetch = tests[i].exp_error ? 0 : eff_rd;
            u_slave.wr_log.delete();
            for (int k = 0; k < MAX_BYTES; k++) begin
                wr_bytes[k] = 8'($random(seed));
            end
            apb_write(ADDR_WDATA0, {wr_bytes[3], wr_bytes[2], wr_bytes[1], wr_bytes[0]},
                      slverr);
            apb_write(ADDR_WDATA1, {wr_bytes[7], wr_bytes[6], wr_bytes[5], wr_bytes[4]},
                      slverr);
            apb_write(ADDR_CTRL, {16'd0, tests[i].rd_cnt, tests[i].wr_cnt, tests[i].addr,
                                  1'b1}, slverr);
            if (tests[i].busy_write) begin
                apb_read(ADDR_STATUS, word, slverr);
                check_flag(word[0], 1'b1, "busy before second CTRL write");
                // Different target and counts that must not take effect
                apb_write(ADDR_CTRL, {16'd0, 4'd1, 4'd1, 7'h3C, 1'b1}, slverr);
                check_flag(slverr, 1'b0, "pslverr on CTRL write while busy");
            end

            // Wait for busy to drop
            do begin
                apb_read(ADDR_STATUS, word, slverr);
            end while (word[0]);
            st     = '{busy: word[0], finish: word[1], error: word[2]};
            st_exp = '{busy: 1'b0, finish: 1'b1, error: tests[i].exp_error};
            check_status(st, st_exp, "STATUS at end");
            check_pad(pad, '0, "pad after transfer");

            apb_read(ADDR_CTRL, word, slverr);
            check_word(word, {16'd0, 4'(eff_rd), 4'(eff_wr), tests[i].addr, 1'b0},
                       "CTRL readback");

            check_word(32'(u_slave.wr_log.size()), 32'(exp_rec), "recorded byte count");
            for (int k = 0; k < exp_rec && k < u_slave.wr_log.size(); k++) begin
                check_byte(u_slave.wr_log[k], wr_bytes[k], $sformatf("write byte %0d", k));
            end
            check_word(32'(u_slave.rd_idx), 32'(exp_fetch), "bytes fetched from slave");

            // Read data only for bytes this transfer fetched
            apb_read(ADDR_RDATA0, word, slverr);
            rd_all[31:0] = word;
            apb_read(ADDR_RDATA1, word, slverr);
            rd_all[63:32] = word;
            for (int k = 0; k < eff_rd && !tests[i].exp_error; k++) begin
                check_byte(rd_all[8*k +: 8], 8'hA0 + 8'(k), $sformatf("read byte %0d", k));
            end

            report_test($sformatf("transfer %0d addr %h wr %0d rd %0d", i, tests[i].addr,
                                  tests[i].wr_cnt, tests[i].rd_cnt), err_before);
        end

        // Error responses of the register block
        err_before = errors;
        apb_read(8'h18, word, slverr);
        check_flag(slverr, 1'b1, "pslverr on read of 0x18");
        apb_write(8'h18, 32'h1234_5678, slverr);
        check_flag(slverr, 1'b1, "pslverr on write of 0x18");
        apb_write(ADDR_STATUS, 32'h7, slverr);
        check_flag(slverr, 1'b1, "pslverr on STATUS write");
        apb_read(ADDR_STATUS, word, slverr);
        check_flag(slverr, 1'b0, "pslverr on STATUS read");
        report_test("register access", err_before);

        $display("%0d tests, %0d failing, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles with a transfer still busy", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* filelist.f */
design/i2c_pkg.sv
design/i2c_apb_regs.sv
design/i2c_scl_timer.sv
design/i2c_byte_shifter.sv
design/i2c_master_fsm.sv
design/i2c_master_top.sv
verif/i2c_slave_model.sv
verif/i2c_tb_top.sv

/* Bender.yml */
package:
  name: i2c_master_apb

sources:
  - files:
      - design/i2c_pkg.sv
      - design/i2c_apb_regs.sv
      - design/i2c_scl_timer.sv
      - design/i2c_byte_shifter.sv
      - design/i2c_master_fsm.sv
      - design/i2c_master_top.sv
  - target: test
    files:
      - verif/i2c_slave_model.sv
      - verif/i2c_tb_top.sv
